/* verilog.f */
+incdir+.
comefa_pkg.sv
comefa_row_array.sv
comefa_pe_array.sv
comefa_write_select.sv
comefa_top.sv
tb_comefa.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --assert -j 0
TOP      := tb_comefa
FILELIST := verilog.f

OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST)) comefa_defs.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* tb_comefa.sv */
`include "comefa_defs.svh"

module tb_comefa;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int K_WR = 0;
    localparam int K_RD = 1;
    localparam int K_RST = 2;
    localparam int P_MASK = 0;
    localparam int P_CARRY = 1;
    localparam int P_NCARRY = 2;
    localparam int P_ALWAYS = 3;
    localparam int W_SHL = 0;
    localparam int W_LOC = 1;
    localparam int W_SHR = 2;

    // Table entry with the rd_data expected one cycle after it is applied
    typedef struct {
        int                kind;
        comefa_pkg::addr_t addr;
        comefa_pkg::word_t data;
        comefa_pkg::word_t exp;
    } entry_t;

    logic              clk;
    logic              c_rst;
    comefa_pkg::addr_t wr_addr;
    comefa_pkg::word_t wr_data;
    logic              wr_en;
    comefa_pkg::addr_t rd_addr;
    comefa_pkg::word_t rd_data;

    entry_t            tbl [$];
    comefa_pkg::row_t  m_rows [`NUM_ROWS];
    comefa_pkg::row_t  m_carry;
    comefa_pkg::row_t  m_mask;
    comefa_pkg::word_t m_rd;
    int                seed;
    int                errors;
    int                cycles;
    int                cycle_limit;

    comefa_top dut_i (
        .clk     (clk),
        .c_rst   (c_rst),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .wr_en   (wr_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: no end of test after %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic check(input string name, input comefa_pkg::word_t got,
                         input comefa_pkg::word_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic comefa_pkg::word_t rand_word();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return r[`DWIDTH-1:0];
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model updated while the table is built
    ////////////////////////////////////////////////////////////////////////////

    task automatic push_entry(input int kind, input comefa_pkg::addr_t addr,
                              input comefa_pkg::word_t data);
        entry_t e;
        e.kind = kind;
        e.addr = addr;
        e.data = data;
        e.exp  = m_rd;
        tbl.push_back(e);
    endtask

    task automatic add_write(input int r, input int w, input comefa_pkg::word_t data);
        m_rows[r][w*`DWIDTH +: `DWIDTH] = data;
        push_entry(K_WR, 9'(r * 4 + w), data);
    endtask

    task automatic add_read(input int r, input int w);
        m_rd = m_rows[r][w*`DWIDTH +: `DWIDTH];
        push_entry(K_RD, 9'(r * 4 + w), '0);
    endtask

    task automatic read_row(input int r);
        for (int w = 0; w < `WORDS_PER_ROW; w++) begin
            add_read(r, w);
        end
    endtask

    task automatic add_reset();
        m_carry = '0;
        m_mask  = '0;
        m_rd    = '0;
        push_entry(K_RST, '0, '0);
    endtask

    task automatic add_cmd(input int pred, input int bsel, input int bdata, input int wen,
                           input int wsel, input int port, input int cclr, input int cen,
                           input int mclr, input int men, input logic [3:0] tt,
                           input int dst, input int s2, input int s1);
        comefa_pkg::row_t  r1;
        comefa_pkg::row_t  r2;
        comefa_pkg::row_t  t;
        comefa_pkg::row_t  s;
        comefa_pkg::row_t  co;
        comefa_pkg::row_t  pr;
        comefa_pkg::row_t  w;
        logic              a;
        logic              b;
        r1 = m_rows[s1];
        r2 = m_rows[s2];
        for (int i = 0; i < `NUM_COLS; i++) begin
            a     = r1[i];
            b     = (bsel != 0) ? (bdata != 0) : r2[i];
            t[i]  = tt[{b, a}];
            s[i]  = t[i] ^ m_carry[i];
            co[i] = (a & b) | (a & m_carry[i]) | (b & m_carry[i]);
        end
        case (pred)
            P_MASK:   pr = m_mask;
            P_CARRY:  pr = m_carry;
            P_NCARRY: pr = ~m_carry;
            default:  pr = '1;
        endcase
        // Zero enters at column 0 on a left shift and at the top column on a right shift
        for (int i = 0; i < `NUM_COLS; i++) begin
            if (port == 0) begin
                w[i] = (wsel == W_LOC) ? s[i] : ((i == 0) ? 1'b0 : s[i-1]);
            end else begin
                w[i] = (wsel == W_LOC) ? m_carry[i] : ((i == `NUM_COLS-1) ? 1'b0 : s[i+1]);
            end
            if (wen != 0 && pr[i]) begin
                m_rows[dst][i] = w[i];
            end
        end
        if (cclr != 0) begin
            m_carry = '0;
        end else if (cen != 0) begin
            m_carry = co;
        end
        if (mclr != 0) begin
            m_mask = '0;
        end else if (men != 0) begin
            m_mask = t;
        end
        push_entry(K_WR, `CMD_ADDR, {2'(pred), 3'b000, 1'(bsel), 1'(bdata), 1'(wen),
                   2'(wsel), 1'(port), 1'(cclr), 1'(cen), 1'(mclr), 1'(men), tt,
                   7'(dst), 7'(s2), 7'(s1)});
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////////////////////

    task automatic build_table();
        for (int r = 0; r < 16; r++) begin
            for (int w = 0; w < `WORDS_PER_ROW; w++) begin
                add_write(r, w, rand_word());
            end
        end
        for (int r = 0; r < 4; r++) begin
            read_row(r);
            // rd_data must hold through a write in a read slot
            add_write(15, r, rand_word());
            add_read(15, r);
        end
        // Bitwise ops and the constant operand with both values
        add_cmd(P_ALWAYS, 0, 0, 1, W_LOC, 0, 0, 0, 0, 0, 4'b0110, 8, 1, 0);
        add_cmd(P_ALWAYS, 0, 0, 1, W_LOC, 0, 0, 0, 0, 0, 4'b1000, 9, 3, 2);
        add_cmd(P_ALWAYS, 0, 0, 1, W_LOC, 0, 0, 0, 0, 0, 4'b1110, 10, 5, 4);
        add_cmd(P_ALWAYS, 1, 1, 1, W_LOC, 0, 0, 0, 0, 0, 4'b0110, 11, 0, 6);
        add_cmd(P_ALWAYS, 1, 0, 1, W_LOC, 0, 0, 0, 0, 0, 4'b1000, 12, 0, 7);
        for (int r = 8; r < 13; r++) begin
            read_row(r);
        end
        // 4 bit add of rows 0..3 and rows 4..7 followed by the carry row
        add_cmd(P_ALWAYS, 0, 0, 0, W_LOC, 0, 1, 0, 0, 0, 4'b0110, 0, 0, 0);
        for (int k = 0; k < 4; k++) begin
            add_cmd(P_ALWAYS, 0, 0, 1, W_LOC, 0, 0, 1, 0, 0, 4'b0110, 8 + k, 4 + k, k);
        end
        add_cmd(P_ALWAYS, 0, 0, 1, W_LOC, 1, 0, 0, 0, 0, 4'b0000, 12, 0, 0);
        for (int r = 8; r < 13; r++) begin
            read_row(r);
        end
        // Mask loaded from row 0 for the predicated writes
        add_cmd(P_ALWAYS, 0, 0, 0, W_LOC, 0, 0, 0, 0, 1, 4'b1010, 0, 1, 0);
        add_cmd(P_MASK, 0, 0, 1, W_LOC, 0, 0, 0, 0, 0, 4'b1000, 13, 2, 1);
        add_cmd(P_CARRY, 0, 0, 1, W_LOC, 0, 0, 0, 0, 0, 4'b1110, 14, 4, 3);
        add_cmd(P_NCARRY, 0, 0, 1, W_LOC, 0, 0, 0, 0, 0, 4'b0110, 15, 6, 5);
        // Shifts
        add_cmd(P_ALWAYS, 0, 0, 1, W_SHL, 0, 0, 0, 0, 0, 4'b0110, 8, 2, 1);
        add_cmd(P_ALWAYS, 0, 0, 1, W_SHR, 1, 0, 0, 0, 0, 4'b1110, 9, 4, 3);
        for (int r = 13; r < 16; r++) begin
            read_row(r);
        end
        read_row(8);
        read_row(9);
        // Predicated writes after reset leave the rows alone
        add_reset();
        add_cmd(P_CARRY, 0, 0, 1, W_LOC, 0, 0, 0, 0, 0, 4'b1111, 10, 0, 0);
        add_cmd(P_MASK, 0, 0, 1, W_LOC, 0, 0, 0, 0, 0, 4'b1111, 11, 0, 0);
        read_row(10);
        read_row(11);
        // Both latches loaded from rows 0 and 1 and then cleared by command
        add_cmd(P_ALWAYS, 0, 0, 0, W_LOC, 0, 0, 1, 0, 1, 4'b0110, 0, 1, 0);
        add_cmd(P_ALWAYS, 0, 0, 0, W_LOC, 0, 1, 0, 1, 0, 4'b0000, 0, 0, 0);
        add_cmd(P_CARRY, 0, 0, 1, W_LOC, 0, 0, 0, 0, 0, 4'b1111, 12, 0, 0);
        add_cmd(P_MASK, 0, 0, 1, W_LOC, 0, 0, 0, 0, 0, 4'b1111, 13, 0, 0);
        read_row(12);
        read_row(13);
    endtask

    task automatic apply_entry(input entry_t e);
        c_rst   = (e.kind == K_RST);
        wr_en   = (e.kind == K_WR);
        wr_addr = e.addr;
        wr_data = e.data;
        rd_addr = (e.kind == K_RD) ? e.addr : comefa_pkg::addr_t'($random(seed));
    endtask

    initial begin
        seed    = 32'hc5b4_34b6;
        errors  = 0;
        cycles  = 0;
        m_carry = '0;
        m_mask  = '0;
        m_rd    = '0;
        build_table();
        cycle_limit = 4 * tbl.size() + 50;
        clk     = 1'b0;
        c_rst   = 1'b1;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        rd_addr = '0;
        repeat (5) @(negedge clk);
        // First entry goes out on the edge that releases reset
        foreach (tbl[i]) begin
            if (i > 0) begin
                @(negedge clk);
                check("rd_data", rd_data, tbl[i-1].exp);
            end
            apply_entry(tbl[i]);
        end
        @(negedge clk);
        check("rd_data", rd_data, tbl[tbl.size()-1].exp);
        $display("Test done after %0d entries, %0d error(s)", tbl.size(), errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* comefa_top.sv */
`include "comefa_defs.svh"

module comefa_top (
    input  logic               clk,
    input  logic               c_rst,
    input  comefa_pkg::addr_t  wr_addr,
    input  comefa_pkg::word_t  wr_data,
    input  logic               wr_en,
    input  comefa_pkg::addr_t  rd_addr,
    output comefa_pkg::word_t  rd_data
);

    logic               compute_valid;
    comefa_pkg::cmd_t   cmd;
    comefa_pkg::row_t   op1_row;
    comefa_pkg::row_t   op2_row;
    comefa_pkg::row_t   sum;
    comefa_pkg::row_t   carry_row;
    comefa_pkg::row_t   col_we;
    comefa_pkg::row_t   wr_row;

    // A write to the reserved word is a command, not data
    assign compute_valid = wr_en && (wr_addr == `CMD_ADDR);
    assign cmd           = comefa_pkg::cmd_t'(wr_data);

    comefa_row_array u_row_array (
        .clk           (clk),
        .c_rst         (c_rst),
        .wr_en         (wr_en),
        .compute_valid (compute_valid),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .rd_addr       (rd_addr),
        .src1          (cmd.src1),
        .src2          (cmd.src2),
        .dst           (cmd.dst),
        .wr_row        (wr_row),
        .col_we        (col_we),
        .op1_row       (op1_row),
        .op2_row       (op2_row),
        .rd_data       (rd_data)
    );

    comefa_pe_array u_pe_array (
        .clk           (clk),
        .c_rst         (c_rst),
        .compute_valid (compute_valid),
        .op1_row       (op1_row),
        .op2_row       (op2_row),
        .b_sel         (cmd.b_sel),
        .b_data        (cmd.b_data),
        .write_en      (cmd.write_en),
        .predicate     (cmd.predicate),
        .truth_table   (cmd.truth_table),
        .carry_clr     (cmd.carry_clr),
        .carry_en      (cmd.carry_en),
        .mask_clr      (cmd.mask_clr),
        .mask_en       (cmd.mask_en),
        .sum           (sum),
        .carry_row     (carry_row),
        .col_we        (col_we)
    );

    comefa_write_select u_write_select (
        .clk           (clk),
        .compute_valid (compute_valid),
        .write_en      (cmd.write_en),
        .sum           (sum),
        .carry_row     (carry_row),
        .port          (cmd.port),
        .write_sel     (cmd.write_sel),
        .wr_row        (wr_row)
    );

endmodule

/* comefa_write_select.sv */
`include "comefa_defs.svh"

module comefa_write_select (
    input  logic               clk,
    input  logic               compute_valid,
    input  logic               write_en,
    input  comefa_pkg::row_t   sum,
    input  comefa_pkg::row_t   carry_row,
    input  logic               port,
    input  comefa_pkg::wsel_e  write_sel,
    output comefa_pkg::row_t   wr_row
);

    comefa_pkg::row_t sum_shl;
    comefa_pkg::row_t sum_shr;

    // Neighbour network, zero shifted in at the row edges
    assign sum_shl = {sum[`NUM_COLS-2:0], 1'b0};
    assign sum_shr = {1'b0, sum[`NUM_COLS-1:1]};

    ////////////////////////////////////////////////////////////////////////////
    // Two write ports per column
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        wr_row = '0;
        if (!port) begin
            case (write_sel)
                comefa_pkg::wsel_shift_left: wr_row = sum_shl;
                comefa_pkg::wsel_local:      wr_row = sum;
                default:                     wr_row = '0;
            endcase
        end else begin
            case (write_sel)
                comefa_pkg::wsel_local:       wr_row = carry_row;
                comefa_pkg::wsel_shift_right: wr_row = sum_shr;
                default:                      wr_row = '0;
            endcase
        end
    end

    // Port 0 has no right shift, port 1 has no left shift
    a_legal_wsel: assert property (
        @(posedge clk)
        (compute_valid && write_en) |->
            (port ? (write_sel inside {comefa_pkg::wsel_local, comefa_pkg::wsel_shift_right})
                  : (write_sel inside {comefa_pkg::wsel_shift_left, comefa_pkg::wsel_local}))
    );

endmodule

/* comefa_pe_array.sv */
`include "comefa_defs.svh"

module comefa_pe_array (
    input  logic                clk,
    input  logic                c_rst,
    input  logic                compute_valid,
    input  comefa_pkg::row_t    op1_row,
    input  comefa_pkg::row_t    op2_row,
    input  logic                b_sel,
    input  logic                b_data,
    input  logic                write_en,
    input  comefa_pkg::pred_e   predicate,
    input  comefa_pkg::tt_t     truth_table,
    input  logic                carry_clr,
    input  logic                carry_en,
    input  logic                mask_clr,
    input  logic                mask_en,
    output comefa_pkg::row_t    sum,
    output comefa_pkg::row_t    carry_row,
    output comefa_pkg::row_t    col_we
);

    comefa_pkg::row_t carry_q;
    comefa_pkg::row_t mask_q;
    comefa_pkg::row_t tt_out;
    comefa_pkg::row_t carry_out;
    comefa_pkg::row_t pred_row;

    ////////////////////////////////////////////////////////////////////////////
    // Bit processors, one per column
    ////////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < `NUM_COLS; i++) begin : g_col
        logic a;
        logic b;

        assign a = op1_row[i];
        // Constant operand replaces the second row
        assign b = b_sel ? b_data : op2_row[i];

        assign tt_out[i] = truth_table[{b, a}];
        assign sum[i]    = tt_out[i] ^ carry_q[i];

        // Majority of both operands and the old carry
        assign carry_out[i] = (a & b) | (a & carry_q[i]) | (b & carry_q[i]);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Predication
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (predicate)
            comefa_pkg::pred_mask:      pred_row = mask_q;
            comefa_pkg::pred_carry:     pred_row = carry_q;
            comefa_pkg::pred_not_carry: pred_row = ~carry_q;
            default:                    pred_row = '1;
        endcase
    end

    assign col_we    = pred_row & {`NUM_COLS{write_en}};
    assign carry_row = carry_q;

    ////////////////////////////////////////////////////////////////////////////
    // Carry and mask latches
    ////////////////////////////////////////////////////////////////////////////

    // Updated at the same edge as the row write, so this cycle sees old values
    always_ff @(posedge clk) begin
        if (c_rst) begin
            carry_q <= '0;
            mask_q  <= '0;
        end else if (compute_valid) begin
            if (carry_clr) begin
                carry_q <= '0;
            end else if (carry_en) begin
                carry_q <= carry_out;
            end
            if (mask_clr) begin
                mask_q <= '0;
            end else if (mask_en) begin
                mask_q <= tt_out;
            end
        end
    end

    // Clear and load of one latch in the same command is ambiguous
    a_latch_ctrl: assert property (
        @(posedge clk) disable iff (c_rst)
        compute_valid |-> !(carry_clr && carry_en) && !(mask_clr && mask_en)
    );

endmodule

/* comefa_row_array.sv */
`include "comefa_defs.svh"

module comefa_row_array (
    input  logic                  clk,
    input  logic                  c_rst,
    input  logic                  wr_en,
    input  logic                  compute_valid,
    input  comefa_pkg::addr_t     wr_addr,
    input  comefa_pkg::word_t     wr_data,
    input  comefa_pkg::addr_t     rd_addr,
    input  comefa_pkg::row_addr_t src1,
    input  comefa_pkg::row_addr_t src2,
    input  comefa_pkg::row_addr_t dst,
    input  comefa_pkg::row_t      wr_row,
    input  comefa_pkg::row_t      col_we,
    output comefa_pkg::row_t      op1_row,
    output comefa_pkg::row_t      op2_row,
    output comefa_pkg::word_t     rd_data
);

    localparam int WSEL_W = `AWIDTH - `ROW_AWIDTH;

    comefa_pkg::row_t mem [`NUM_ROWS];

    // Word address splits into row and slice within the row
    comefa_pkg::row_addr_t wr_row_idx;
    logic [WSEL_W-1:0]     wr_word_idx;
    comefa_pkg::row_addr_t rd_row_idx;
    logic [WSEL_W-1:0]     rd_word_idx;
    comefa_pkg::row_t      rd_row;
    comefa_pkg::word_t     rd_word;

    assign wr_row_idx  = wr_addr[`AWIDTH-1 -: `ROW_AWIDTH];
    assign wr_word_idx = wr_addr[WSEL_W-1:0];
    assign rd_row_idx  = rd_addr[`AWIDTH-1 -: `ROW_AWIDTH];
    assign rd_word_idx = rd_addr[WSEL_W-1:0];

    // Operand rows for the bit processors
    assign op1_row = mem[src1];
    assign op2_row = mem[src2];

    ////////////////////////////////////////////////////////////////////////////
    // Array writes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (compute_valid) begin
            // Unselected columns keep their old bits
            mem[dst] <= (mem[dst] & ~col_we) | (wr_row & col_we);
        end else if (wr_en) begin
            for (int w = 0; w < `WORDS_PER_ROW; w++) begin
                if (wr_word_idx == WSEL_W'(w)) begin
                    mem[wr_row_idx][w*`DWIDTH +: `DWIDTH] <= wr_data;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Registered word read
    ////////////////////////////////////////////////////////////////////////////

    assign rd_row = mem[rd_row_idx];

    always_comb begin
        rd_word = '0;
        for (int w = 0; w < `WORDS_PER_ROW; w++) begin
            if (rd_word_idx == WSEL_W'(w)) begin
                rd_word = rd_row[w*`DWIDTH +: `DWIDTH];
            end
        end
    end

    // Read is skipped in any cycle with a write, rd_data holds
    always_ff @(posedge clk) begin
        if (c_rst) begin
            rd_data <= '0;
        end else if (!wr_en) begin
            rd_data <= rd_word;
        end
    end

    // Command address must always be decoded as compute mode by the top
    a_cmd_addr_is_compute: assert property (
        @(posedge clk) disable iff (c_rst)
        (wr_en && wr_addr == `CMD_ADDR) |-> compute_valid
    );

endmodule

/* comefa_pkg.sv */
`include "comefa_defs.svh"

package comefa_pkg;

    typedef logic [`NUM_COLS-1:0] row_t;
    typedef logic [`DWIDTH-1:0] word_t;
    typedef logic [`AWIDTH-1:0] addr_t;
    typedef logic [`ROW_AWIDTH-1:0] row_addr_t;

    // Indexed by {b, a}
    typedef logic [`TT_WIDTH-1:0] tt_t;

    // Which latch gates the per-column write
    typedef enum logic [`PRED_WIDTH-1:0] {
        pred_mask      = 2'b00,
        pred_carry     = 2'b01,
        pred_not_carry = 2'b10,
        pred_always    = 2'b11
    } pred_e;

    // Port 0 takes shift_left or local, port 1 takes local or shift_right
    typedef enum logic [`WSEL_WIDTH-1:0] {
        wsel_shift_left  = 2'b00,
        wsel_local       = 2'b01,
        wsel_shift_right = 2'b10
    } wsel_e;

    ////////////////////////////////////////////////////////////////////////
    // Compute command, carried on the write data bus
    ////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        pred_e                        predicate;
        logic [`CMD_UNUSED_WIDTH-1:0] unused;
        logic                         b_sel;
        logic                         b_data;
        logic                         write_en;
        wsel_e                        write_sel;
        logic                         port;
        logic                         carry_clr;
        logic                         carry_en;
        logic                         mask_clr;
        logic                         mask_en;
        tt_t                          truth_table;
        row_addr_t                    dst;
        row_addr_t                    src2;
        row_addr_t                    src1;
    } cmd_t;

endpackage

/* comefa_defs.svh */
`ifndef COMEFA_DEFS_SVH
`define COMEFA_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// External word view
////////////////////////////////////////////////////////////////////////////

`define AWIDTH 9
`define DWIDTH 40

////////////////////////////////////////////////////////////////////////////
// Internal row view, 128 rows of 160 columns
////////////////////////////////////////////////////////////////////////////

`define NUM_COLS 160
`define NUM_ROWS 128
`define ROW_AWIDTH 7
`define WORDS_PER_ROW 4

// Top word address, a write here is a compute command
`define CMD_ADDR 9'd511

// Command field widths
`define PRED_WIDTH 2
`define CMD_UNUSED_WIDTH 3
`define WSEL_WIDTH 2
`define TT_WIDTH 4

`endif
